// ==== hdl/mdu_pkg.sv ====
// shared widths, RV64 M-extension encodings and result-select codes
// imported by every module of the multiply/divide unit
`default_nettype none

package mdu_pkg;

    localparam int XLEN       = 64;   // datapath width
    localparam int WORD_LEN   = 32;   // W-form operand width
    localparam int INST_WIDTH = 32;

    // major opcodes
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;  // reg-reg
    localparam logic [6:0] OPCODE_OP_32  = 7'b0111011;  // reg-reg, word forms
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;  // M extension

    localparam logic [2:0] FUNCT3_MUL    = 3'b000;
    localparam logic [2:0] FUNCT3_MULH   = 3'b001;
    localparam logic [2:0] FUNCT3_MULHSU = 3'b010;
    localparam logic [2:0] FUNCT3_MULHU  = 3'b011;
    localparam logic [2:0] FUNCT3_DIV    = 3'b100;  // bit 2 set on every divide form
    localparam logic [2:0] FUNCT3_DIVU   = 3'b101;
    localparam logic [2:0] FUNCT3_REM    = 3'b110;
    localparam logic [2:0] FUNCT3_REMU   = 3'b111;  // bit 0 set means unsigned divide

    // which datapath output reaches writeback
    localparam int RESULT_SEL_WIDTH = 3;

    localparam logic [RESULT_SEL_WIDTH-1:0] SEL_NONE      = 3'd0;  // not an M op, data zero
    localparam logic [RESULT_SEL_WIDTH-1:0] SEL_PROD_LO   = 3'd1;
    localparam logic [RESULT_SEL_WIDTH-1:0] SEL_PROD_HI   = 3'd2;
    localparam logic [RESULT_SEL_WIDTH-1:0] SEL_QUOT      = 3'd3;
    localparam logic [RESULT_SEL_WIDTH-1:0] SEL_REM       = 3'd4;
    localparam logic [RESULT_SEL_WIDTH-1:0] SEL_PROD_LO_W = 3'd5;  // word forms are
    localparam logic [RESULT_SEL_WIDTH-1:0] SEL_QUOT_W    = 3'd6;  // sign-extended
    localparam logic [RESULT_SEL_WIDTH-1:0] SEL_REM_W     = 3'd7;  // from bit 31

    // full product, or the same bits seen as two halves
    typedef union packed {
        logic [2*XLEN-1:0]       full;
        logic [1:0][XLEN-1:0]    half;  // [1] high, [0] low
    } product_t;

endpackage

`default_nettype wire

// ==== hdl/mdu_decode.sv ====
// instruction decode for the multiply/divide unit
// splits the instruction, extends W-form operands, flags zero divisors
// and picks the writeback result-select code, all in zero cycles
`timescale 1ns/1ps
`default_nettype none

module mdu_decode (
    input  logic [mdu_pkg::INST_WIDTH-1:0]       inst_i,
    input  logic [mdu_pkg::XLEN-1:0]             data1_i,
    input  logic [mdu_pkg::XLEN-1:0]             data2_i,
    output logic                                 executed_o,
    output logic                                 exception_o,
    output logic                                 sign_a_o,
    output logic                                 sign_b_o,
    output logic                                 div_signed_o,
    output logic                                 div_word_o,
    output logic [mdu_pkg::RESULT_SEL_WIDTH-1:0] result_sel_o,
    output logic [mdu_pkg::XLEN-1:0]             operand_a_o,
    output logic [mdu_pkg::XLEN-1:0]             operand_b_o,
    output logic [mdu_pkg::XLEN-1:0]             divisor_o
);
    import mdu_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_div;     // any divide or remainder form
    logic       div_zero;   // divisor, or its low word, is zero

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    always_comb
    begin
        executed_o   = 1'b1;
        div_word_o   = 1'b0;
        result_sel_o = SEL_NONE;
        if (opcode == OPCODE_OP && funct7 == FUNCT7_MULDIV)
        begin
            case (funct3)
                FUNCT3_MUL:                               result_sel_o = SEL_PROD_LO;
                FUNCT3_MULH, FUNCT3_MULHSU, FUNCT3_MULHU: result_sel_o = SEL_PROD_HI;
                FUNCT3_DIV, FUNCT3_DIVU:                  result_sel_o = SEL_QUOT;
                default:                                  result_sel_o = SEL_REM;
            endcase
        end
        else if (opcode == OPCODE_OP_32 && funct7 == FUNCT7_MULDIV)
        begin
            div_word_o = 1'b1;
            case (funct3)
                FUNCT3_MUL:              result_sel_o = SEL_PROD_LO_W;
                FUNCT3_DIV, FUNCT3_DIVU: result_sel_o = SEL_QUOT_W;
                FUNCT3_REM, FUNCT3_REMU: result_sel_o = SEL_REM_W;
                default:                 executed_o   = 1'b0;  // no high-half word forms
            endcase
        end
        else
        begin
            executed_o = 1'b0;  // not an M instruction, passes through empty
        end
    end

    // funct3 bit 2 marks the divides, bit 0 their unsigned variants
    assign is_div       = executed_o & funct3[2];
    assign div_signed_o = is_div & ~funct3[0];

    // only the high half cares about signedness
    assign sign_a_o = (result_sel_o == SEL_PROD_HI) & (funct3 != FUNCT3_MULHU);
    assign sign_b_o = (result_sel_o == SEL_PROD_HI) & (funct3 == FUNCT3_MULH);

    // W forms take the low word, sign- or zero-extended by signedness
    assign operand_a_o = div_word_o ?
        {{(XLEN-WORD_LEN){div_signed_o & data1_i[WORD_LEN-1]}}, data1_i[WORD_LEN-1:0]} :
        data1_i;
    assign operand_b_o = div_word_o ?
        {{(XLEN-WORD_LEN){div_signed_o & data2_i[WORD_LEN-1]}}, data2_i[WORD_LEN-1:0]} :
        data2_i;

    assign divisor_o = is_div ? operand_b_o : XLEN'(1);  // idle divider sees 1

    assign div_zero    = div_word_o ? (data2_i[WORD_LEN-1:0] == '0) : (data2_i == '0);
    assign exception_o = is_div & div_zero;  // multiplies never trap

endmodule

`default_nettype wire

// ==== hdl/mdu_multiplier.sv ====
// full-width signed/unsigned multiplier
// one extra sign or zero bit per operand gives all three signedness mixes,
// then DEPTH plain registers follow so synthesis can retime the multiply
`timescale 1ns/1ps
`default_nettype none

module mdu_multiplier #(
    parameter int DEPTH = 4
) (
    input  logic                     clk,
    input  logic [mdu_pkg::XLEN-1:0] operand_a_i,
    input  logic [mdu_pkg::XLEN-1:0] operand_b_i,
    input  logic                     sign_a_i,
    input  logic                     sign_b_i,
    output mdu_pkg::product_t        product_o
);
    import mdu_pkg::*;

    logic signed [XLEN:0]     a_ext;
    logic signed [XLEN:0]     b_ext;
    logic signed [2*XLEN-1:0] full_prod;  // low 2*XLEN bits of the extended product
    product_t                 prod_q [DEPTH];

    assign a_ext = {sign_a_i & operand_a_i[XLEN-1], operand_a_i};
    assign b_ext = {sign_b_i & operand_b_i[XLEN-1], operand_b_i};

    assign full_prod = a_ext * b_ext;

    // delay line, entry 0 takes the raw product
    always_ff @(posedge clk)
    begin
        prod_q[0].full <= full_prod;
        for (int k = 1; k < DEPTH; k++)
        begin
            prod_q[k] <= prod_q[k-1];
        end
    end

    assign product_o = prod_q[DEPTH-1];

endmodule

`default_nettype wire

// ==== hdl/mdu_divider.sv ====
// pipelined restoring divider, XLEN/DEPTH quotient bits per stage
// works on magnitudes and fixes the signs at the end of the pipe
// a zero divisor leaves quotient all ones and remainder equal to the dividend
`timescale 1ns/1ps
`default_nettype none

module mdu_divider #(
    parameter int DEPTH = 4
) (
    input  logic                     clk,
    input  logic [mdu_pkg::XLEN-1:0] dividend_i,
    input  logic [mdu_pkg::XLEN-1:0] divisor_i,
    input  logic                     div_signed_i,
    output logic [mdu_pkg::XLEN-1:0] quotient_o,
    output logic [mdu_pkg::XLEN-1:0] remainder_o
);
    import mdu_pkg::*;

    localparam int STEPS = XLEN / DEPTH;

    logic            neg_a;
    logic            neg_b;
    logic            div_zero;
    logic [XLEN-1:0] mag_a;
    logic [XLEN-1:0] mag_b;
    logic [XLEN-1:0] quo_mag;
    logic [XLEN-1:0] rem_mag;

    // per stage state
    logic [2*XLEN-1:0] rq_q       [DEPTH];  // {partial remainder, dividend/quotient bits}
    logic [XLEN-1:0]   dvs_q      [DEPTH];  // divisor magnitude
    logic [XLEN-1:0]   dividend_q [DEPTH];  // original dividend for the zero case
    logic              neg_q_q    [DEPTH];
    logic              neg_r_q    [DEPTH];
    logic              zero_q     [DEPTH];

    // STEPS iterations of shift, trial subtract, restore
    function automatic logic [2*XLEN-1:0] div_steps(
        input logic [2*XLEN-1:0] rq_in,
        input logic [XLEN-1:0]   dvs
    );
        logic [2*XLEN-1:0] rq;
        logic [XLEN:0]     cand;
        logic [XLEN:0]     diff;
        logic              ge;
        rq = rq_in;
        for (int s = 0; s < STEPS; s++)
        begin
            cand = rq[2*XLEN-1:XLEN-1];  // remainder with next dividend bit shifted in
            diff = cand - {1'b0, dvs};
            ge   = (cand >= {1'b0, dvs});
            rq   = {(ge ? diff[XLEN-1:0] : cand[XLEN-1:0]), rq[XLEN-2:0], ge};
        end
        return rq;
    endfunction

    assign neg_a    = div_signed_i & dividend_i[XLEN-1];
    assign neg_b    = div_signed_i & divisor_i[XLEN-1];
    assign mag_a    = neg_a ? -dividend_i : dividend_i;
    assign mag_b    = neg_b ? -divisor_i : divisor_i;
    assign div_zero = (divisor_i == '0);

    always_ff @(posedge clk)
    begin
        rq_q[0]       <= div_steps({{XLEN{1'b0}}, mag_a}, mag_b);
        dvs_q[0]      <= mag_b;
        dividend_q[0] <= dividend_i;
        neg_q_q[0]    <= (neg_a ^ neg_b) & ~div_zero;  // keep all ones on /0
        neg_r_q[0]    <= neg_a;                        // remainder follows dividend sign
        zero_q[0]     <= div_zero;
        for (int k = 1; k < DEPTH; k++)
        begin
            rq_q[k]       <= div_steps(rq_q[k-1], dvs_q[k-1]);
            dvs_q[k]      <= dvs_q[k-1];
            dividend_q[k] <= dividend_q[k-1];
            neg_q_q[k]    <= neg_q_q[k-1];
            neg_r_q[k]    <= neg_r_q[k-1];
            zero_q[k]     <= zero_q[k-1];
        end
    end

    assign quo_mag = rq_q[DEPTH-1][XLEN-1:0];
    assign rem_mag = rq_q[DEPTH-1][2*XLEN-1:XLEN];

    // sign fix-up, min / -1 wraps back to min with no extra logic
    assign quotient_o  = neg_q_q[DEPTH-1] ? -quo_mag : quo_mag;
    assign remainder_o = zero_q[DEPTH-1]  ? dividend_q[DEPTH-1] :
                         neg_r_q[DEPTH-1] ? -rem_mag : rem_mag;

endmodule

`default_nettype wire

// ==== hdl/mdu_writeback_pipe.sv ====
// control delay line and writeback select for the multiply/divide unit
// valid, tag and flags ride DEPTH registers next to the datapaths; a recovery
// clears every valid bit and blocks the incoming one
// outputs are zero whenever the final valid is low
`timescale 1ns/1ps
`default_nettype none

module mdu_writeback_pipe #(
    parameter int DEPTH     = 4,
    parameter int TAG_WIDTH = 8
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 recover_i,
    input  logic                                 valid_i,
    input  logic [TAG_WIDTH-1:0]                 tag_i,
    input  logic                                 dest_valid_i,
    input  logic                                 executed_i,
    input  logic                                 exception_i,
    input  logic [mdu_pkg::RESULT_SEL_WIDTH-1:0] result_sel_i,
    input  mdu_pkg::product_t                    product_i,
    input  logic [mdu_pkg::XLEN-1:0]             quotient_i,
    input  logic [mdu_pkg::XLEN-1:0]             remainder_i,
    output logic                                 wb_valid_o,
    output logic [TAG_WIDTH-1:0]                 wb_tag_o,
    output logic [mdu_pkg::XLEN-1:0]             wb_data_o,
    output logic                                 executed_o,
    output logic                                 exception_o,
    output logic                                 dest_valid_o
);
    import mdu_pkg::*;

    localparam int CTRL_W = TAG_WIDTH + 3 + RESULT_SEL_WIDTH;

    logic                        valid_q [DEPTH];
    logic [CTRL_W-1:0]           ctrl_q  [DEPTH];  // tag, flags, select
    logic [TAG_WIDTH-1:0]        tag_d;
    logic                        dv_d;
    logic                        exec_d;
    logic                        exc_d;
    logic [RESULT_SEL_WIDTH-1:0] sel_d;
    logic [XLEN-1:0]             sel_data;

    function automatic logic [XLEN-1:0] sext_word(input logic [XLEN-1:0] v);
        return {{(XLEN-WORD_LEN){v[WORD_LEN-1]}}, v[WORD_LEN-1:0]};
    endfunction

    // valid bits, the only reset state
    always_ff @(posedge clk)
    begin
        if (reset || recover_i)
        begin
            for (int k = 0; k < DEPTH; k++)
            begin
                valid_q[k] <= 1'b0;  // flush everything in flight
            end
        end
        else
        begin
            valid_q[0] <= valid_i;
            for (int k = 1; k < DEPTH; k++)
            begin
                valid_q[k] <= valid_q[k-1];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        ctrl_q[0] <= {tag_i, dest_valid_i, executed_i, exception_i, result_sel_i};
        for (int k = 1; k < DEPTH; k++)
        begin
            ctrl_q[k] <= ctrl_q[k-1];
        end
    end

    assign {tag_d, dv_d, exec_d, exc_d, sel_d} = ctrl_q[DEPTH-1];

    // datapath outputs arrive aligned with the last control stage
    always_comb
    begin
        sel_data = '0;  // SEL_NONE
        case (sel_d)
            SEL_PROD_LO:   sel_data = product_i.half[0];
            SEL_PROD_HI:   sel_data = product_i.half[1];
            SEL_QUOT:      sel_data = quotient_i;
            SEL_REM:       sel_data = remainder_i;
            SEL_PROD_LO_W: sel_data = sext_word(product_i.half[0]);
            SEL_QUOT_W:    sel_data = sext_word(quotient_i);
            SEL_REM_W:     sel_data = sext_word(remainder_i);
            default:       sel_data = '0;
        endcase
    end

    assign wb_valid_o   = valid_q[DEPTH-1];
    assign wb_tag_o     = wb_valid_o ? tag_d : '0;
    assign executed_o   = wb_valid_o & exec_d;
    assign exception_o  = executed_o & exc_d;
    assign dest_valid_o = executed_o & dv_d;  // non-M ops never write a register
    assign wb_data_o    = executed_o ? sel_data : '0;

endmodule

`default_nettype wire

// ==== hdl/mdu_top.sv ====
// RV64 multiply/divide unit, fixed latency DEPTH, one op per cycle
// decode feeds the multiplier and divider, writeback pipe lines up
// the control and picks the result; recover_i kills everything in flight
`timescale 1ns/1ps
`default_nettype none

module mdu_top #(
    parameter int DEPTH     = 4,   // must divide XLEN
    parameter int TAG_WIDTH = 8
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             recover_i,
    input  logic                             valid_i,
    input  logic [mdu_pkg::INST_WIDTH-1:0]   inst_i,
    input  logic [mdu_pkg::XLEN-1:0]         data1_i,
    input  logic [mdu_pkg::XLEN-1:0]         data2_i,
    input  logic [TAG_WIDTH-1:0]             tag_i,
    input  logic                             dest_valid_i,
    output logic                             wb_valid_o,
    output logic [TAG_WIDTH-1:0]             wb_tag_o,
    output logic [mdu_pkg::XLEN-1:0]         wb_data_o,
    output logic                             executed_o,
    output logic                             exception_o,
    output logic                             dest_valid_o
);
    import mdu_pkg::*;

    logic [XLEN-1:0]             operand_a;
    logic [XLEN-1:0]             operand_b;
    logic [XLEN-1:0]             divisor;
    logic                        sign_a;
    logic                        sign_b;
    logic                        div_signed;
    logic                        executed;
    logic                        exception;
    logic [RESULT_SEL_WIDTH-1:0] result_sel;
    product_t                    product;
    logic [XLEN-1:0]             quotient;
    logic [XLEN-1:0]             remainder;

    mdu_decode u_decode (
        .inst_i       (inst_i),
        .data1_i      (data1_i),
        .data2_i      (data2_i),
        .executed_o   (executed),
        .exception_o  (exception),
        .sign_a_o     (sign_a),
        .sign_b_o     (sign_b),
        .div_signed_o (div_signed),
        .div_word_o   (),  // word operands reach the divider already extended
        .result_sel_o (result_sel),
        .operand_a_o  (operand_a),
        .operand_b_o  (operand_b),
        .divisor_o    (divisor)
    );

    mdu_multiplier #(.DEPTH(DEPTH)) u_mult (
        .clk         (clk),
        .operand_a_i (operand_a),
        .operand_b_i (operand_b),
        .sign_a_i    (sign_a),
        .sign_b_i    (sign_b),
        .product_o   (product)
    );

    mdu_divider #(.DEPTH(DEPTH)) u_div (
        .clk          (clk),
        .dividend_i   (operand_a),
        .divisor_i    (divisor),
        .div_signed_i (div_signed),
        .quotient_o   (quotient),
        .remainder_o  (remainder)
    );

    mdu_writeback_pipe #(.DEPTH(DEPTH), .TAG_WIDTH(TAG_WIDTH)) u_wb (
        .clk          (clk),
        .reset        (reset),
        .recover_i    (recover_i),
        .valid_i      (valid_i),
        .tag_i        (tag_i),
        .dest_valid_i (dest_valid_i),
        .executed_i   (executed),
        .exception_i  (exception),
        .result_sel_i (result_sel),
        .product_i    (product),
        .quotient_i   (quotient),
        .remainder_i  (remainder),
        .wb_valid_o   (wb_valid_o),
        .wb_tag_o     (wb_tag_o),
        .wb_data_o    (wb_data_o),
        .executed_o   (executed_o),
        .exception_o  (exception_o),
        .dest_valid_o (dest_valid_o)
    );

endmodule

`default_nettype wire

// ==== tests/mdu_tb.sv ====
// random-stimulus testbench for the multiply/divide unit
// drives mdu_top on falling edges, predicts each result with a behavioural
// model and checks every cycle, idle or not, against the expectation queue
`timescale 1ns/1ps
`default_nettype none

module mdu_tb;
    import mdu_pkg::*;

    localparam int DEPTH      = 4;
    localparam int TAG_WIDTH  = 8;
    localparam int CLK_PERIOD = 100;
    localparam int N_OPS      = 3000;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  recover_i;
    logic                  valid_i;
    logic [INST_WIDTH-1:0] inst_i;
    logic [XLEN-1:0]       data1_i;
    logic [XLEN-1:0]       data2_i;
    logic [TAG_WIDTH-1:0]  tag_i;
    logic                  dest_valid_i;
    logic                  wb_valid_o;
    logic [TAG_WIDTH-1:0]  wb_tag_o;
    logic [XLEN-1:0]       wb_data_o;
    logic                  executed_o;
    logic                  exception_o;
    logic                  dest_valid_o;

    logic [31:0] lfsr = 32'h69d92170;
    int          cyc;
    // expectations, one entry per surviving issue, ordered by due cycle
    int             due_q  [$];
    logic [XLEN-1:0] data_q [$];
    logic [TAG_WIDTH-1:0] tag_q [$];
    logic [2:0]     flag_q [$];  // {executed, exception, dest_valid}
    string          name_q [$];

    mdu_top #(.DEPTH(DEPTH), .TAG_WIDTH(TAG_WIDTH)) uut (
        .clk(clk), .reset(reset), .recover_i(recover_i), .valid_i(valid_i),
        .inst_i(inst_i), .data1_i(data1_i), .data2_i(data2_i), .tag_i(tag_i),
        .dest_valid_i(dest_valid_i), .wb_valid_o(wb_valid_o), .wb_tag_o(wb_tag_o),
        .wb_data_o(wb_data_o), .executed_o(executed_o), .exception_o(exception_o),
        .dest_valid_o(dest_valid_o)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);  // one step per bit
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // leans on the corner values of both divide widths
    function automatic logic [63:0] pick_operand();
        logic [2:0] kind;
        kind = 3'(take_bits(3));
        case (kind)
            3'd0:    return '0;
            3'd1:    return '1;
            3'd2:    return 64'h8000_0000_0000_0000;
            3'd3:    return 64'hffff_ffff_8000_0000;
            3'd4:    return take_bits(32) << 32;  // zero low word
            3'd5:    return take_bits(4);
            default: return take_bits(64);
        endcase
    endfunction

    function automatic string op_name(input int op);
        case (op)
            0:       return "MUL";
            1:       return "MULH";
            2:       return "MULHSU";
            3:       return "MULHU";
            4:       return "DIV";
            5:       return "DIVU";
            6:       return "REM";
            7:       return "REMU";
            8:       return "MULW";
            9:       return "DIVW";
            10:      return "DIVUW";
            11:      return "REMW";
            12:      return "REMUW";
            default: return "NON_M";
        endcase
    endfunction

    // r holds rd, rs1, rs2 and a spare funct3 for the non-M form
    function automatic logic [31:0] encode_op(input int op, input logic [17:0] r);
        logic [6:0] f7;
        logic [6:0] opc;
        logic [2:0] f3;
        f7  = FUNCT7_MULDIV;
        opc = (op >= 8) ? OPCODE_OP_32 : OPCODE_OP;
        case (op)
            8:       f3 = FUNCT3_MUL;
            9:       f3 = FUNCT3_DIV;
            10:      f3 = FUNCT3_DIVU;
            11:      f3 = FUNCT3_REM;
            12:      f3 = FUNCT3_REMU;
            13:
            begin
                f7 = 7'b0;  // plain ALU op
                f3 = r[17:15];
            end
            default: f3 = 3'(op);  // funct3 equals the index for the 64-bit forms
        endcase
        return {f7, r[14:10], r[9:5], f3, r[4:0], opc};
    endfunction

    // RISC-V M semantics, straight from the spec
    function automatic logic [63:0] model_result(input int op, input logic [63:0] a,
                                                 input logic [63:0] b);
        logic [127:0]       prod;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [31:0]        aw;
        logic [31:0]        bw;
        logic signed [31:0] saw;
        logic signed [31:0] sbw;
        logic [31:0]        rw;
        logic [63:0]        r;
        sa  = a;
        sb  = b;
        aw  = a[31:0];
        bw  = b[31:0];
        saw = aw;
        sbw = bw;
        rw  = '0;
        r   = '0;
        case (op)
            0: r = a * b;
            1:
            begin
                prod = {{64{a[63]}}, a} * {{64{b[63]}}, b};
                r    = prod[127:64];
            end
            2:
            begin
                prod = {{64{a[63]}}, a} * {64'h0, b};  // signed x unsigned
                r    = prod[127:64];
            end
            3:
            begin
                prod = {64'h0, a} * {64'h0, b};
                r    = prod[127:64];
            end
            4: r = (b == 0) ? -64'sd1 : (a == 64'h8000_0000_0000_0000 && b == '1) ? sa : sa / sb;
            5: r = (b == 0) ? '1 : a / b;
            6: r = (b == 0) ? sa : (a == 64'h8000_0000_0000_0000 && b == '1) ? 64'sd0 : sa % sb;
            7: r = (b == 0) ? a : a % b;
            8: rw = aw * bw;
            9: rw = (bw == 0) ? -32'sd1 : (aw == 32'h8000_0000 && bw == '1) ? saw : saw / sbw;
            10: rw = (bw == 0) ? '1 : aw / bw;
            11: rw = (bw == 0) ? saw : (aw == 32'h8000_0000 && bw == '1) ? 32'sd0 : saw % sbw;
            12: rw = (bw == 0) ? aw : aw % bw;
            default: r = '0;
        endcase
        if (op >= 8 && op <= 12)
        begin
            r = {{32{rw[31]}}, rw};  // word results always sign-extended
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected)
        begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "mismatch in cycle %0d", cyc);
        end
    endtask

    task automatic compare_outputs();
        string      nm;
        logic [2:0] fl;
        if (due_q.size() != 0 && due_q[0] == cyc)
        begin
            void'(due_q.pop_front());
            nm = name_q.pop_front();
            fl = flag_q.pop_front();
            check_value({nm, " valid"}, 1, wb_valid_o);
            check_value({nm, " data"}, data_q.pop_front(), wb_data_o);
            check_value({nm, " tag"}, tag_q.pop_front(), wb_tag_o);
            check_value({nm, " executed"}, fl[2], executed_o);
            check_value({nm, " exception"}, fl[1], exception_o);
            check_value({nm, " dest_valid"}, fl[0], dest_valid_o);
        end
        else
        begin
            // nothing due, every output must rest at zero
            check_value("idle valid", 0, wb_valid_o);
            check_value("idle data", 0, wb_data_o);
            check_value("idle tag", 0, wb_tag_o);
            check_value("idle flags", 0, {executed_o, exception_o, dest_valid_o});
        end
    endtask

    task automatic issue_random();
        int          op;
        logic [63:0] a;
        logic [63:0] b;
        logic        exc;
        op           = int'(take_bits(4) % 14);
        a            = pick_operand();
        b            = pick_operand();
        inst_i       = encode_op(op, 18'(take_bits(18)));
        data1_i      = a;
        data2_i      = b;
        tag_i        = TAG_WIDTH'(take_bits(TAG_WIDTH));
        dest_valid_i = 1'(take_bits(1));
        valid_i      = (take_bits(2) != 0);  // about three in four cycles
        recover_i    = (take_bits(4) == 0);
        exc = ((op >= 4 && op <= 7) && b == 0) || ((op >= 9 && op <= 12) && b[31:0] == 0);
        if (recover_i)
        begin
            // kills this issue and the ones still in flight, not the one due now
            while (due_q.size() != 0 && due_q[$] > cyc)
            begin
                void'(due_q.pop_back());
                void'(data_q.pop_back());
                void'(tag_q.pop_back());
                void'(flag_q.pop_back());
                void'(name_q.pop_back());
            end
        end
        else if (valid_i)
        begin
            due_q.push_back(cyc + DEPTH);
            data_q.push_back(model_result(op, a, b));
            tag_q.push_back(tag_i);
            flag_q.push_back({op != 13, exc, (op != 13) & dest_valid_i});
            name_q.push_back(op_name(op));
        end
    endtask

    // watchdog, twice the nominal run length
    initial
    begin
        #((N_OPS + 20) * CLK_PERIOD * 2);
        $display("timeout, the run did not finish in time");
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        reset        = 1'b1;
        recover_i    = 1'b0;
        valid_i      = 1'b0;
        inst_i       = '0;
        data1_i      = '0;
        data2_i      = '0;
        tag_i        = '0;
        dest_valid_i = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        cyc   = 0;
        for (int i = 0; i < N_OPS + DEPTH + 2; i++)
        begin
            compare_outputs();  // outputs settled since the rising edge
            if (i < N_OPS)
            begin
                issue_random();
            end
            else
            begin
                valid_i   = 1'b0;  // drain
                recover_i = 1'b0;
            end
            @(negedge clk);
            cyc++;
        end
        if (due_q.size() != 0)
        begin
            $display("results still expected after the drain, %0d missing", due_q.size());
            $display("*** FAILED ***");
            $fatal(1, "pipeline lost results");
        end
        else
        begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
hdl/mdu_pkg.sv
hdl/mdu_decode.sv
hdl/mdu_multiplier.sv
hdl/mdu_divider.sv
hdl/mdu_writeback_pipe.sv
hdl/mdu_top.sv
tests/mdu_tb.sv

// ==== Bender.yml ====
package:
  name: mdu

sources:
  - hdl/mdu_pkg.sv
  - hdl/mdu_decode.sv
  - hdl/mdu_multiplier.sv
  - hdl/mdu_divider.sv
  - hdl/mdu_writeback_pipe.sv
  - hdl/mdu_top.sv
  - target: test
    files:
      - tests/mdu_tb.sv
